// File: common/counter_macros.svh
`ifndef COUNTER_MACROS_SVH
`define COUNTER_MACROS_SVH

// counter and target width.
`define CNT_WIDTH     32
`define INNER_NUM     4

// 0 extern a, 1 extern b, 2..5 inner din 0..3, others tie low.
`define SRC_SEL_WIDTH 3

`define CAP_SLOTS     3
`define INT_NUM       2   // bit 0 capture full, bit 1 period match.

// edge qualifier codes.
`define EDGE_RISE     2'd0
`define EDGE_FALL     2'd1
`define EDGE_BOTH     2'd2
`define EDGE_NONE     2'd3

`endif

// File: common/counter_pkg.sv
`include "counter_macros.svh"

package counter_pkg;

    // counter value and compare targets.
    typedef logic [`CNT_WIDTH-1:0]     count_t;

    typedef logic [`SRC_SEL_WIDTH-1:0] src_sel_t;
    typedef logic [1:0]                edge_sel_t;

    // one bit per capture slot.
    typedef logic [`CAP_SLOTS-1:0]     slot_mask_t;
    typedef logic [1:0]                slot_idx_t;   // next slot to fill.

    // run state of the channel.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAVE,
        ST_CAPTURE
    } run_state_e;

endpackage

// File: trigger/event_select.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module event_select import counter_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_extern_din_a,
    input  logic                  i_extern_din_b,
    input  logic [`INNER_NUM-1:0] i_inner_din,
    input  src_sel_t              i_src_sel,
    input  edge_sel_t             i_edge_sel,
    output logic                  o_event
);

    logic       src;
    logic [1:0] samp_q;   // [0] newest sample.
    logic       edge_hit;

    always_comb begin
        case (i_src_sel)
            src_sel_t'(0): src = i_extern_din_a;
            src_sel_t'(1): src = i_extern_din_b;
            src_sel_t'(2): src = i_inner_din[0];
            src_sel_t'(3): src = i_inner_din[1];
            src_sel_t'(4): src = i_inner_din[2];
            src_sel_t'(5): src = i_inner_din[3];
            default:       src = 1'b0;
        endcase
    end

    // compare the last two samples.
    always_comb begin
        case (i_edge_sel)
            `EDGE_RISE: edge_hit = samp_q[0] & ~samp_q[1];
            `EDGE_FALL: edge_hit = ~samp_q[0] & samp_q[1];
            `EDGE_BOTH: edge_hit = samp_q[0] ^ samp_q[1];
            `EDGE_NONE: edge_hit = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            samp_q  <= 2'b00;
            o_event <= 1'b0;
        end else begin
            samp_q  <= {samp_q[0], src};
            o_event <= edge_hit;   // two edges after the input moves.
        end
    end

endmodule

// File: timer/timer_core.sv
`timescale 1ns/1ps

module timer_core import counter_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_enable,
    input  logic       i_mode_wave,
    input  logic       i_period_stop,
    input  logic       i_start_event,
    input  logic       i_stop_event,
    input  logic       i_sw_start,
    input  logic       i_sw_stop,
    input  logic       i_sw_clear,
    input  count_t     i_target_t2,
    output run_state_e o_state,
    output count_t     o_count,
    output logic       o_start_evt,
    output logic       o_clear_evt,
    output logic       o_period_hit
);

    logic       sw_start_q;
    logic       sw_stop_q;
    logic       sw_clear_q;
    logic       start_req;
    logic       stop_req;
    logic       run_start;
    run_state_e state_d;

    // software triggers act on any change of level.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sw_start_q <= 1'b0;
            sw_stop_q  <= 1'b0;
            sw_clear_q <= 1'b0;
        end else begin
            sw_start_q <= i_sw_start;
            sw_stop_q  <= i_sw_stop;
            sw_clear_q <= i_sw_clear;
        end
    end

    assign start_req    = i_start_event | (i_sw_start ^ sw_start_q);
    assign stop_req     = i_stop_event | (i_sw_stop ^ sw_stop_q);
    assign o_clear_evt  = i_sw_clear ^ sw_clear_q;
    assign run_start    = i_enable & start_req & ~stop_req;   // stop wins.
    assign o_start_evt  = run_start & i_mode_wave;            // only wave runs load the pin.
    assign o_period_hit = (o_state == ST_WAVE) && (o_count == i_target_t2);

    always_comb begin
        state_d = o_state;
        if (!i_enable || stop_req) begin
            state_d = ST_IDLE;
        end else if (start_req) begin
            state_d = i_mode_wave ? ST_WAVE : ST_CAPTURE;
        end else if (o_period_hit && i_period_stop) begin
            state_d = ST_IDLE;   // one-shot period end.
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state <= ST_IDLE;
            o_count <= '0;
        end else begin
            o_state <= state_d;
            if (!i_enable || o_clear_evt) begin
                o_count <= '0;
            end else if (o_state != ST_IDLE) begin
                if (o_period_hit) begin
                    if (!i_period_stop)
                        o_count <= '0;   // restart the period.
                end else begin
                    o_count <= o_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/waveform_gen.sv
`timescale 1ns/1ps

module waveform_gen import counter_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  run_state_e i_state,
    input  count_t     i_count,
    input  logic       i_start_evt,
    input  logic       i_period_hit,
    input  count_t     i_target_t0,
    input  count_t     i_target_t1,
    input  logic       i_keep_at_period,
    input  logic       i_dout_rst_val,
    output logic       o_dout,
    output logic       o_dout_oen
);

    logic in_wave;

    assign in_wave = (i_state == ST_WAVE);

    // compare pin, t0 first, then t1, then the period end.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dout <= 1'b0;
        end else if (i_start_evt) begin
            o_dout <= i_dout_rst_val;
        end else if (in_wave) begin
            if (i_count == i_target_t0) begin
                o_dout <= 1'b0;
            end else if (i_count == i_target_t1) begin
                o_dout <= 1'b1;
            end else if (i_period_hit && !i_keep_at_period) begin
                o_dout <= i_dout_rst_val;
            end
        end
    end

    // pin drives only while running in wave mode.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_dout_oen <= 1'b1;
        else
            o_dout_oen <= ~in_wave;   // active low.
    end

endmodule

// File: capture/capture_unit.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module capture_unit import counter_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_enable,
    input  run_state_e i_state,
    input  count_t     i_count,
    input  logic       i_cap_event,
    input  logic       i_clear_evt,
    input  slot_mask_t i_read_ack,
    input  slot_mask_t i_overwrite,
    output count_t     o_cap0,
    output count_t     o_cap1,
    output count_t     o_cap2,
    output slot_mask_t o_cap_status
);

    count_t     cap_q [`CAP_SLOTS];
    slot_idx_t  idx_q;
    slot_mask_t ack_q;
    slot_mask_t ack_rise;
    slot_mask_t cur_slot;
    slot_mask_t wr_en;
    logic       cap_take;
    logic       flush;

    assign flush    = ~i_enable | i_clear_evt;
    assign cap_take = i_cap_event && (i_state == ST_CAPTURE);
    assign ack_rise = i_read_ack & ~ack_q;
    assign cur_slot = slot_mask_t'(1) << idx_q;

    // write a free slot, a slot read this cycle, or an overwrite slot.
    assign wr_en = {`CAP_SLOTS{cap_take}} & cur_slot & (~o_cap_status | ack_rise | i_overwrite);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            ack_q <= '0;
        else
            ack_q <= i_read_ack;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx_q        <= '0;
            o_cap_status <= '0;
        end else if (flush) begin
            idx_q        <= '0;
            o_cap_status <= '0;
        end else if (cap_take) begin
            // slot order 0, 1, 2, 0.
            idx_q        <= (idx_q == slot_idx_t'(`CAP_SLOTS - 1)) ? '0 : idx_q + 1'b1;
            o_cap_status <= (o_cap_status & ~ack_rise) | cur_slot;
        end else begin
            o_cap_status <= o_cap_status & ~ack_rise;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `CAP_SLOTS; i++)
                cap_q[i] <= '0;
        end else begin
            for (int i = 0; i < `CAP_SLOTS; i++) begin
                if (flush)
                    cap_q[i] <= '0;
                else if (wr_en[i])
                    cap_q[i] <= i_count;   // otherwise discarded.
            end
        end
    end

    assign o_cap0 = cap_q[0];
    assign o_cap1 = cap_q[1];
    assign o_cap2 = cap_q[2];

endmodule

// File: logic/int_gen.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module int_gen import counter_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  slot_mask_t          i_cap_status,
    input  logic                i_period_hit,
    output logic [`INT_NUM-1:0] o_int
);

    logic all_full;
    logic all_full_q;
    logic period_hit_q;

    assign all_full = &i_cap_status;   // every slot holds a capture.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            all_full_q   <= 1'b0;
            period_hit_q <= 1'b0;
        end else begin
            all_full_q   <= all_full;
            period_hit_q <= i_period_hit;
        end
    end

    // one-cycle pulses on the rising edges.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_int <= '0;
        end else begin
            o_int[0] <= all_full & ~all_full_q;
            o_int[1] <= i_period_hit & ~period_hit_q;
        end
    end

endmodule

// File: logic/counter_top.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module counter_top import counter_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_enable,
    input  logic                  i_mode_wave,
    input  logic                  i_extern_din_a,
    input  logic                  i_extern_din_b,
    input  logic [`INNER_NUM-1:0] i_inner_din,
    input  logic                  i_sw_start,
    input  logic                  i_sw_stop,
    input  logic                  i_sw_clear,
    input  src_sel_t              i_sel_start,
    input  edge_sel_t             i_edge_start,
    input  src_sel_t              i_sel_stop,
    input  edge_sel_t             i_edge_stop,
    input  src_sel_t              i_sel_cap,
    input  edge_sel_t             i_edge_cap,
    input  count_t                i_target_t0,
    input  count_t                i_target_t1,
    input  count_t                i_target_t2,
    input  logic                  i_period_stop,
    input  logic                  i_keep_at_period,
    input  logic                  i_dout_rst_val,
    input  slot_mask_t            i_read_ack,
    input  slot_mask_t            i_overwrite,
    output count_t                o_count,
    output logic                  o_dout_a,
    output logic                  o_dout_a_oen,
    output count_t                o_cap0,
    output count_t                o_cap1,
    output count_t                o_cap2,
    output slot_mask_t            o_cap_status,
    output logic [`INT_NUM-1:0]   o_int
);

    logic       start_evt;
    logic       stop_evt;
    logic       cap_evt;
    logic       run_start_evt;
    logic       clear_evt;
    logic       period_hit;
    run_state_e state;

    // event qualifiers for start, stop and capture.
    event_select u_start_sel (
        .i_clk, .i_rst_n, .i_extern_din_a, .i_extern_din_b, .i_inner_din,
        .i_src_sel(i_sel_start), .i_edge_sel(i_edge_start), .o_event(start_evt)
    );

    event_select u_stop_sel (
        .i_clk, .i_rst_n, .i_extern_din_a, .i_extern_din_b, .i_inner_din,
        .i_src_sel(i_sel_stop), .i_edge_sel(i_edge_stop), .o_event(stop_evt)
    );

    event_select u_cap_sel (
        .i_clk, .i_rst_n, .i_extern_din_a, .i_extern_din_b, .i_inner_din,
        .i_src_sel(i_sel_cap), .i_edge_sel(i_edge_cap), .o_event(cap_evt)
    );

    timer_core u_timer_core (
        .i_clk, .i_rst_n, .i_enable, .i_mode_wave, .i_period_stop,
        .i_start_event(start_evt), .i_stop_event(stop_evt),
        .i_sw_start, .i_sw_stop, .i_sw_clear, .i_target_t2,
        .o_state(state), .o_count, .o_start_evt(run_start_evt),
        .o_clear_evt(clear_evt), .o_period_hit(period_hit)
    );

    waveform_gen u_waveform_gen (
        .i_clk, .i_rst_n, .i_state(state), .i_count(o_count),
        .i_start_evt(run_start_evt), .i_period_hit(period_hit),
        .i_target_t0, .i_target_t1, .i_keep_at_period, .i_dout_rst_val,
        .o_dout(o_dout_a), .o_dout_oen(o_dout_a_oen)
    );

    capture_unit u_capture_unit (
        .i_clk, .i_rst_n, .i_enable, .i_state(state), .i_count(o_count),
        .i_cap_event(cap_evt), .i_clear_evt(clear_evt), .i_read_ack, .i_overwrite,
        .o_cap0, .o_cap1, .o_cap2, .o_cap_status
    );

    int_gen u_int_gen (
        .i_clk, .i_rst_n, .i_cap_status(o_cap_status), .i_period_hit(period_hit), .o_int
    );

endmodule

// File: sim/counter_asserts.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module counter_asserts import counter_pkg::*; (
    input logic                i_clk,
    input logic                i_rst_n,
    input run_state_e          i_state,
    input count_t              i_count,
    input logic                i_dout_oen,
    input logic [`INT_NUM-1:0] i_int
);

    // enable follows the state by one edge.
    a_oen_wave: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_dout_oen |-> $past(i_state) == ST_WAVE)
        else $error("pin enabled outside wave mode");

    a_int_cap_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_int[0] |=> !i_int[0])
        else $error("capture full interrupt longer than one cycle");

    a_int_period_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_int[1] |=> !i_int[1])
        else $error("period interrupt longer than one cycle");

    // idle count only holds or clears.
    a_idle_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_IDLE) |=> (i_count == $past(i_count) || i_count == '0))
        else $error("count moved while idle");

endmodule

// File: sim/counter_tb.sv
`timescale 1ns/1ps
`include "counter_macros.svh"

module counter_tb import counter_pkg::*; ();

    typedef struct packed {
        logic       wave;
        src_sel_t   sel_start;
        edge_sel_t  edge_start;
        src_sel_t   sel_cap;
        edge_sel_t  edge_cap;
        count_t     t0;
        count_t     t1;
        count_t     t2;
        logic       period_stop;
        logic       keep;
        logic       rst_val;
        slot_mask_t overwrite;
        int         checks;       // cycles compared against the wave model.
        int         exp_int1;     // period pulses expected.
        slot_mask_t exp_status;   // status after the read acknowledge.
        int         len;          // cycle budget of the row.
    } row_t;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n, i_enable, i_mode_wave;
    logic                  i_extern_din_a, i_extern_din_b;
    logic [`INNER_NUM-1:0] i_inner_din;
    logic                  i_sw_start, i_sw_stop, i_sw_clear;
    src_sel_t              i_sel_start, i_sel_stop, i_sel_cap;
    edge_sel_t             i_edge_start, i_edge_stop, i_edge_cap;
    count_t                i_target_t0, i_target_t1, i_target_t2;
    logic                  i_period_stop, i_keep_at_period, i_dout_rst_val;
    slot_mask_t            i_read_ack, i_overwrite;
    count_t                o_count, o_cap0, o_cap1, o_cap2;
    logic                  o_dout_a, o_dout_a_oen;
    slot_mask_t            o_cap_status;
    logic [`INT_NUM-1:0]   o_int;

    row_t   rows [4];
    integer seed;
    int     cycles = 0;
    int     limit = 0;
    int     n_int0;
    int     n_int1;

    counter_top dut (.*);

    bind counter_top counter_asserts u_asserts (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_state(state), .i_count(o_count),
        .i_dout_oen(o_dout_a_oen), .i_int(o_int)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // advance one falling edge and count interrupt pulses.
    task automatic next_cycle();
        @(negedge i_clk);
        if (o_int[0])
            n_int0 = n_int0 + 1;
        if (o_int[1])
            n_int1 = n_int1 + 1;
    endtask

    // next count by the period rule.
    function automatic count_t count_after(input count_t cnt, input logic run, input row_t r);
        if (!run)
            return cnt;
        if (r.wave && cnt == r.t2)
            return r.period_stop ? cnt : '0;
        return cnt + 1;
    endfunction

    task automatic apply_row(input row_t r);
        i_mode_wave      = r.wave;
        i_sel_start      = r.sel_start;
        i_edge_start     = r.edge_start;
        i_sel_cap        = r.sel_cap;
        i_edge_cap       = r.edge_cap;
        i_target_t0      = r.t0;
        i_target_t1      = r.t1;
        i_target_t2      = r.t2;
        i_period_stop    = r.period_stop;
        i_keep_at_period = r.keep;
        i_dout_rst_val   = r.rst_val;
        i_overwrite      = r.overwrite;
    endtask

    // pulse extern a and wait until the run is visible.
    task automatic start_run(input logic wave);
        i_extern_din_a = 1'b1;
        next_cycle();
        i_extern_din_a = 1'b0;
        if (wave) begin
            while (o_dout_a_oen)
                next_cycle();
        end else begin
            while (o_count == '0)
                next_cycle();
        end
    endtask

    task automatic stop_and_clear(input count_t exp_held);
        i_sw_stop = ~i_sw_stop;
        next_cycle();
        check_value("o_count", o_count, exp_held);
        repeat (2)
            next_cycle();
        check_value("o_count", o_count, exp_held);   // still frozen.
        check_value("o_dout_a_oen", o_dout_a_oen, 1'b1);
        i_sw_clear = ~i_sw_clear;
        next_cycle();
        check_value("o_count", o_count, 0);
        check_value("o_cap0", o_cap0, 0);
        check_value("o_cap1", o_cap1, 0);
        check_value("o_cap2", o_cap2, 0);
        check_value("o_cap_status", o_cap_status, 0);
    endtask

    task automatic run_wave(input row_t r);
        count_t cnt_m;
        logic   pin_m;
        logic   run_m;
        logic   run_prev;
        logic   hit;
        logic   hit_prev;
        logic   int1_m;
        n_int1 = 0;
        start_run(1'b1);
        cnt_m    = 1;
        pin_m    = r.rst_val;   // loaded by the start event.
        run_m    = 1'b1;
        run_prev = 1'b1;
        hit_prev = 1'b0;
        int1_m   = 1'b0;
        for (int k = 0; k < r.checks; k++) begin
            check_value("o_count", o_count, cnt_m);
            check_value("o_dout_a", o_dout_a, pin_m);
            check_value("o_dout_a_oen", o_dout_a_oen, !run_prev);
            check_value("o_int[1]", o_int[1], int1_m);
            hit = run_m && cnt_m == r.t2;
            if (run_m) begin
                if (cnt_m == r.t0)
                    pin_m = 1'b0;
                else if (cnt_m == r.t1)
                    pin_m = 1'b1;
                else if (hit && !r.keep)
                    pin_m = r.rst_val;
            end
            int1_m   = hit && !hit_prev;
            hit_prev = hit;
            run_prev = run_m;
            cnt_m    = count_after(cnt_m, run_m, r);
            run_m    = run_m && !(hit && r.period_stop);
            next_cycle();
        end
        check_value("period pulses", n_int1, r.exp_int1);
        stop_and_clear(count_after(cnt_m, run_m, r));
    endtask

    task automatic run_capture(input row_t r);
        count_t cnt_m;
        count_t exp_cap [4];
        int     gaps [4];
        n_int0 = 0;
        start_run(1'b0);
        cnt_m = 1;
        check_value("o_count", o_count, cnt_m);
        for (int e = 0; e < 4; e++) begin
            gaps[e]        = 3 + ($random(seed) & 3);
            exp_cap[e]     = cnt_m + 2;   // strobe after two edges, captured on the third.
            i_inner_din[1] = 1'b1;
            for (int g = 0; g < gaps[e]; g++) begin
                next_cycle();
                cnt_m          = cnt_m + 1;
                i_inner_din[1] = 1'b0;
            end
            if (e == 2) begin
                check_value("o_cap_status", o_cap_status, 3'b111);
                check_value("o_cap0", o_cap0, exp_cap[0]);
                check_value("o_cap1 - o_cap0", o_cap1 - o_cap0, gaps[0]);
                check_value("o_cap2 - o_cap1", o_cap2 - o_cap1, gaps[1]);
            end
        end
        // fourth edge hit a full slot 0.
        check_value("o_cap0", o_cap0, r.overwrite[0] ? exp_cap[3] : exp_cap[0]);
        check_value("capture full pulses", n_int0, 1);
        i_read_ack = 3'b010;
        next_cycle();
        cnt_m      = cnt_m + 1;
        i_read_ack = '0;
        check_value("o_cap_status", o_cap_status, r.exp_status);
        stop_and_clear(count_after(cnt_m, 1'b1, r));
    endtask

    initial begin
        seed             = 32'h0df5ff53;
        i_rst_n          = 1'b0;
        i_enable         = 1'b1;
        i_extern_din_a   = 1'b0;
        i_extern_din_b   = 1'b0;
        i_inner_din      = '0;
        i_sw_start       = 1'b0;
        i_sw_stop        = 1'b0;
        i_sw_clear       = 1'b0;
        i_sel_stop       = src_sel_t'(7);   // tied low.
        i_edge_stop      = `EDGE_NONE;
        i_read_ack       = '0;
        rows[0] = '{1'b1, 3'd0, `EDGE_RISE, 3'd7, `EDGE_NONE, 32'd2, 32'd5, 32'd9,
                    1'b0, 1'b0, 1'b1, 3'b000, 25, 2, 3'b000, 45};
        rows[1] = '{1'b1, 3'd0, `EDGE_RISE, 3'd7, `EDGE_NONE, 32'd2, 32'd5, 32'd9,
                    1'b1, 1'b0, 1'b0, 3'b000, 14, 1, 3'b000, 35};
        rows[2] = '{1'b0, 3'd0, `EDGE_RISE, 3'd3, `EDGE_RISE, 32'd2, 32'd5, 32'd9,
                    1'b0, 1'b0, 1'b0, 3'b000, 0, 0, 3'b101, 60};
        rows[3] = '{1'b0, 3'd0, `EDGE_RISE, 3'd3, `EDGE_RISE, 32'd2, 32'd5, 32'd9,
                    1'b0, 1'b0, 1'b0, 3'b001, 0, 0, 3'b101, 60};
        apply_row(rows[0]);
        limit = 100;   // reset and margin.
        for (int r = 0; r < 4; r++)
            limit = limit + rows[r].len;
        repeat (2)
            @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_value("o_dout_a_oen", o_dout_a_oen, 1'b1);
        check_value("o_dout_a", o_dout_a, 1'b0);
        check_value("o_int", o_int, 0);
        check_value("o_count", o_count, 0);
        check_value("o_cap0", o_cap0, 0);
        check_value("o_cap1", o_cap1, 0);
        check_value("o_cap2", o_cap2, 0);
        check_value("o_cap_status", o_cap_status, 0);
        for (int r = 0; r < 4; r++) begin
            apply_row(rows[r]);
            if (rows[r].wave)
                run_wave(rows[r]);
            else
                run_capture(rows[r]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/counter_pkg.sv
trigger/event_select.sv
timer/timer_core.sv
logic/waveform_gen.sv
capture/capture_unit.sv
logic/int_gen.sv
logic/counter_top.sv
sim/counter_asserts.sv
sim/counter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the counter testbench with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module counter_tb -f verilog.f -o counter_sim

status=0
./obj_dir/counter_sim 2>&1 | tee sim.log || status=$?

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
